// ==== sources.f ====
+incdir+include
design/mem_stage_pkg.sv
design/store_lane_align.sv
design/data_ram.sv
design/load_lane_extract.sv
design/mem_stage.sv
tb/tb_mem_stage.sv

// ==== tb/mem_stage_trace.txt ====
# valid op addr wdata misaligned expect_load expected_rdata, all hex
# op: 0 none, 1 sb, 2 sh, 3 sw, 4 lb, 5 lbu, 6 lh, 7 lhu, 8 lw
# idle cycles after reset
0 0 000 00000000 0 0 00000000
0 0 000 00000000 0 0 00000000
# word store then word load
1 3 000 12345678 0 0 00000000
1 8 000 00000000 0 1 12345678
0 0 000 00000000 0 0 00000000
1 3 3fc deadbeef 0 0 00000000
1 8 3fc 00000000 0 1 deadbeef
# byte stores build a word
1 1 004 555555a1 0 0 00000000
1 1 005 777777b2 0 0 00000000
1 1 006 123456c3 0 0 00000000
1 1 007 abcdefd4 0 0 00000000
1 8 004 00000000 0 1 d4c3b2a1
1 1 005 0000005e 0 0 00000000
1 8 004 00000000 0 1 d4c35ea1
# byte loads with sign and zero extension
1 4 004 00000000 0 1 ffffffa1
1 5 004 00000000 0 1 000000a1
1 4 005 00000000 0 1 0000005e
1 4 006 00000000 0 1 ffffffc3
1 5 007 00000000 0 1 000000d4
1 4 007 00000000 0 1 ffffffd4
# halfword loads with sign and zero extension
1 3 008 87659abc 0 0 00000000
1 6 008 00000000 0 1 ffff9abc
1 7 008 00000000 0 1 00009abc
1 6 00a 00000000 0 1 ffff8765
1 7 00a 00000000 0 1 00008765
1 3 00c 7fff1234 0 0 00000000
1 6 00c 00000000 0 1 00001234
1 6 00e 00000000 0 1 00007fff
# misaligned halfword and word accesses
1 3 010 00000000 0 0 00000000
1 2 011 aaaa5a5a 1 0 00000000
1 8 010 00000000 0 1 00005a5a
1 2 013 0000c3c3 1 0 00000000
1 8 010 00000000 0 1 c3c35a5a
1 2 012 00001111 0 0 00000000
1 7 013 00000000 1 1 00001111
1 6 011 00000000 1 1 00005a5a
1 8 011 00000000 1 1 11115a5a
1 8 012 00000000 1 1 11115a5a
1 5 011 00000000 0 1 0000005a
1 3 016 0badf00d 1 0 00000000
1 8 014 00000000 0 1 0badf00d
# strobe low, nothing flagged and nothing written
0 3 013 ffffffff 0 0 00000000
0 3 000 ffffffff 0 0 00000000
0 8 000 00000000 0 0 00000000
# back-to-back loads
1 8 000 00000000 0 1 12345678
1 8 004 00000000 0 1 d4c35ea1
1 8 008 00000000 0 1 87659abc
1 8 3fc 00000000 0 1 deadbeef
# store then load of the same word in the next cycle
1 3 00c 0f0f0f0f 0 0 00000000
1 8 00c 00000000 0 1 0f0f0f0f
1 1 00d 00000099 0 0 00000000
1 8 00c 00000000 0 1 0f0f990f
1 4 00d 00000000 0 1 ffffff99
0 0 000 00000000 0 0 00000000
0 0 000 00000000 0 0 00000000

// ==== tb/tb_mem_stage.sv ====
`default_nettype none

`include "mem_stage_config.svh"

module tb_mem_stage import mem_stage_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;
    localparam int SLACK_CYCLES = 50;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       valid;
    mem_op_t    op;
    byte_addr_t addr;
    word_t      wdata;
    word_t      rdata;
    logic       rdata_valid;
    logic       misaligned;

    // Trace contents, one entry per access line.
    logic       tr_valid[$];
    logic [3:0] tr_op[$];
    byte_addr_t tr_addr[$];
    word_t      tr_wdata[$];
    logic       tr_mis[$];
    logic       tr_load[$];
    word_t      tr_rdata[$];
    int         tr_line[$];

    // Loads in flight, checked one cycle after they are presented.
    word_t      expect_data_q[$];
    string      expect_label_q[$];

    // Words touched by the trace, filled with random data first.
    word_addr_t fill_words[$] = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd255};

    logic [15:0] lfsr_state;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    mem_stage dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .misaligned  (misaligned)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic word_t random_word();
        word_t w;
        for (int i = 0; i < `MEM_DATA_W; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            value_errors++;
        end
    endtask

    task automatic print_summary();
        $display("Errors: %0d value mismatches, %0d other errors", value_errors, other_errors);
    endtask

    // One access per clock; outputs are sampled at the falling edge.
    task automatic apply_cycle(input logic v, input logic [3:0] code, input byte_addr_t a,
                               input word_t d, input logic exp_mis, input logic exp_load,
                               input word_t exp_rdata, input string label);
        word_t exp_word;
        string exp_label;
        @(posedge clk);
        #1;
        valid = v;
        op    = mem_op_t'(code);
        addr  = a;
        wdata = d;
        @(negedge clk);
        check_value(word_t'(misaligned), word_t'(exp_mis), {"misaligned on ", label});
        if (expect_data_q.size() > 0) begin
            exp_word  = expect_data_q.pop_front();
            exp_label = expect_label_q.pop_front();
            if (rdata_valid !== 1'b1) begin
                $display("At %0t ns: rdata_valid missing one cycle after the load on %s",
                         $time, exp_label);
                other_errors++;
            end else begin
                check_value(rdata, exp_word, {"rdata for ", exp_label});
            end
        end else if (rdata_valid !== 1'b0) begin
            $display("At %0t ns: rdata_valid high with no load in the previous cycle (%s)",
                     $time, label);
            other_errors++;
        end
        if (exp_load) begin
            expect_data_q.push_back(exp_rdata);
            expect_label_q.push_back(label);
        end
    endtask

    task automatic load_trace(output logic ok);
        int    fd;
        int    n;
        int    line_no;
        string line;
        logic [31:0] f_valid, f_op, f_addr, f_wdata, f_mis, f_load, f_rdata;
        ok = 1'b0;
        line_no = 0;
        fd = $fopen("tb/mem_stage_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", f_valid, f_op, f_addr,
                                f_wdata, f_mis, f_load, f_rdata);
                    if (n != 7) begin
                        $display("Trace line %0d is malformed and was skipped", line_no);
                        other_errors++;
                    end else begin
                        tr_valid.push_back(f_valid[0]);
                        tr_op.push_back(f_op[3:0]);
                        tr_addr.push_back(byte_addr_t'(f_addr));
                        tr_wdata.push_back(f_wdata);
                        tr_mis.push_back(f_mis[0]);
                        tr_load.push_back(f_load[0]);
                        tr_rdata.push_back(f_rdata);
                        tr_line.push_back(line_no);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    task automatic run_tests();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (fill_words[i]) begin
            apply_cycle(1'b1, MEM_SW, {fill_words[i], 2'b00}, random_word(), 1'b0, 1'b0,
                        '0, $sformatf("preamble store %0d", i));
        end

        foreach (tr_valid[i]) begin
            apply_cycle(tr_valid[i], tr_op[i], tr_addr[i], tr_wdata[i], tr_mis[i],
                        tr_load[i], tr_rdata[i], $sformatf("trace line %0d", tr_line[i]));
        end

        // One idle cycle drains the last load.
        apply_cycle(1'b0, MEM_NONE, '0, '0, 1'b0, 1'b0, '0, "final idle cycle");

        print_summary();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        logic trace_ok;
        rst_n      = 1'b0;
        valid      = 1'b0;
        op         = MEM_NONE;
        addr       = '0;
        wdata      = '0;
        lfsr_state = 16'd50;
        load_trace(trace_ok);
        cycle_limit = RESET_CYCLES + fill_words.size() + tr_valid.size() + 1 + SLACK_CYCLES;
        if (!trace_ok) begin
            $display("Could not open the trace file tb/mem_stage_trace.txt");
            other_errors++;
            print_summary();
            $display("Testbench failed");
            $finish;
        end else begin
            run_tests();
        end
    end

    // Watchdog.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without reaching the end of the trace",
                     cycle_count);
            print_summary();
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
`default_nettype none

`include "mem_stage_config.svh"

module mem_stage import mem_stage_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             valid,
    input  wire mem_op_t    op,
    input  wire byte_addr_t addr,
    input  wire word_t      wdata,
    output word_t           rdata,
    output logic            rdata_valid,
    output logic            misaligned
);

    word_addr_t word_addr;
    lane_off_t  lane_off;
    word_t      lane_data;
    lane_en_t   lane_en;
    word_t      rd_word;

    //////////////////////////////////////////////////////////////////
    // Address split
    //////////////////////////////////////////////////////////////////

    assign word_addr = addr[`MEM_ADDR_W+1:2];
    assign lane_off  = addr[1:0];

    store_lane_align u_store_align (
        .op         (op),
        .lane_off   (lane_off),
        .wdata      (wdata),
        .lane_data  (lane_data),
        .lane_en    (lane_en),
        .misaligned (misaligned),
        .valid      (valid)
    );

    data_ram u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .word_addr (word_addr),
        .lane_data (lane_data),
        .lane_en   (lane_en),
        .rd_word   (rd_word)
    );

    // Load results leave one cycle after the request.
    load_lane_extract u_load_extract (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .op          (op),
        .lane_off    (lane_off),
        .rd_word     (rd_word),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

// ==== design/load_lane_extract.sv ====
`default_nettype none

`include "mem_stage_config.svh"

module load_lane_extract import mem_stage_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            valid,
    input  wire mem_op_t   op,
    input  wire lane_off_t lane_off,
    input  wire word_t     rd_word,
    output word_t          rdata,
    output logic           rdata_valid
);

    localparam int BYTE_W = 8;
    localparam int HALF_W = 16;

    logic              pending;
    mem_op_t           op_q;
    lane_off_t         off_q;
    logic [BYTE_W-1:0] sel_byte;
    logic [HALF_W-1:0] sel_half;

    //////////////////////////////////////////////////////////////////
    // Request capture, in step with the RAM read
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= valid && is_load(op);
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            op_q  <= op;
            off_q <= lane_off;
        end
    end

    assign rdata_valid = pending;

    //////////////////////////////////////////////////////////////////
    // Lane select and extension
    //////////////////////////////////////////////////////////////////

    always_comb begin
        case (off_q)
            2'b00:   sel_byte = rd_word[7:0];
            2'b01:   sel_byte = rd_word[15:8];
            2'b10:   sel_byte = rd_word[23:16];
            default: sel_byte = rd_word[31:24];
        endcase
    end

    // Same halfword rule as the store side.
    assign sel_half = off_q[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (op_q)
            MEM_LB: begin
                rdata = {{(`MEM_DATA_W-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
            end
            MEM_LBU: begin
                rdata = {{(`MEM_DATA_W-BYTE_W){1'b0}}, sel_byte};
            end
            MEM_LH: begin
                rdata = {{(`MEM_DATA_W-HALF_W){sel_half[HALF_W-1]}}, sel_half};
            end
            MEM_LHU: begin
                rdata = {{(`MEM_DATA_W-HALF_W){1'b0}}, sel_half};
            end
            MEM_LW: begin
                rdata = rd_word;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

    // A store or an idle cycle never produces a load result.
    a_no_spurious_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(valid && is_load(op)) |=> !rdata_valid
    ) else $error("rdata_valid raised without a load");

endmodule

`default_nettype wire

// ==== design/data_ram.sv ====
`default_nettype none

`include "mem_stage_config.svh"

module data_ram import mem_stage_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             valid,
    input  wire word_addr_t word_addr,
    input  wire word_t      lane_data,
    input  wire lane_en_t   lane_en,
    output word_t           rd_word
);

    localparam int DEPTH  = 1 << `MEM_ADDR_W;
    localparam int LANE_W = `MEM_DATA_W / `MEM_LANES;

    word_t mem [DEPTH];
    logic  wr_en;

    //////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////

    assign wr_en = valid && (lane_en != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                if (lane_en[i]) begin
                    mem[word_addr][LANE_W*i +: LANE_W] <= lane_data[LANE_W*i +: LANE_W];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////

    // Read and write share the edge, so a write to the same word
    // shows up on the next read only.
    always_ff @(posedge clk) begin
        if (valid) begin
            rd_word <= mem[word_addr];
        end
    end

    // An unknown address would corrupt or read an arbitrary word.
    a_addr_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |-> !$isunknown(word_addr)
    ) else $error("data RAM accessed with unknown address");

endmodule

`default_nettype wire

// ==== design/store_lane_align.sv ====
`default_nettype none

`include "mem_stage_config.svh"

module store_lane_align import mem_stage_pkg::*; (
    input  wire mem_op_t   op,
    input  wire lane_off_t lane_off,
    input  wire word_t     wdata,
    output word_t          lane_data,
    output lane_en_t       lane_en,
    output logic           misaligned,
    input  wire            valid
);

    logic half_op;
    logic word_op;

    //////////////////////////////////////////////////////////////////
    // Lane placement
    //////////////////////////////////////////////////////////////////

    always_comb begin
        lane_data = '0;
        lane_en   = '0;
        unique case (op)
            MEM_SB: begin
                case (lane_off)
                    2'b00: begin
                        lane_data[7:0] = wdata[7:0];
                        lane_en        = 4'b0001;
                    end
                    2'b01: begin
                        lane_data[15:8] = wdata[7:0];
                        lane_en         = 4'b0010;
                    end
                    2'b10: begin
                        lane_data[23:16] = wdata[7:0];
                        lane_en          = 4'b0100;
                    end
                    default: begin
                        lane_data[31:24] = wdata[7:0];
                        lane_en          = 4'b1000;
                    end
                endcase
            end
            MEM_SH: begin
                // Offset bit 0 does not move the half.
                if (lane_off[1]) begin
                    lane_data[31:16] = wdata[15:0];
                    lane_en          = 4'b1100;
                end else begin
                    lane_data[15:0] = wdata[15:0];
                    lane_en         = 4'b0011;
                end
            end
            MEM_SW: begin
                lane_data = wdata;
                lane_en   = '1;
            end
            default: begin
                lane_data = '0;
                lane_en   = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // Alignment check
    //////////////////////////////////////////////////////////////////

    assign half_op = op inside {MEM_SH, MEM_LH, MEM_LHU};
    assign word_op = op inside {MEM_SW, MEM_LW};

    // Reported only. The access itself still goes ahead.
    assign misaligned = valid && ((half_op && lane_off[0]) ||
                                  (word_op && (lane_off != 2'b00)));

    // Loads and idle cycles must never touch the RAM.
    always_comb begin
        if (!is_store(op)) begin
            a_no_write_on_load : assert final (lane_en == '0)
                else $error("lane enable set for non-store op %s", op.name());
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_stage_pkg.sv ====
`default_nettype none

`include "mem_stage_config.svh"

package mem_stage_pkg;

    //////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////

    typedef logic [`MEM_DATA_W-1:0] word_t;
    typedef logic [`MEM_LANES-1:0]  lane_en_t;
    typedef logic [`MEM_ADDR_W+1:0] byte_addr_t;
    typedef logic [`MEM_ADDR_W-1:0] word_addr_t;
    typedef logic [1:0]             lane_off_t;

    // Memory operation codes.
    typedef enum logic [3:0] {
        MEM_NONE = 4'h0,
        MEM_SB   = 4'h1,
        MEM_SH   = 4'h2,
        MEM_SW   = 4'h3,
        MEM_LB   = 4'h4,
        MEM_LBU  = 4'h5,
        MEM_LH   = 4'h6,
        MEM_LHU  = 4'h7,
        MEM_LW   = 4'h8
    } mem_op_t;

    function automatic logic is_store(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    function automatic logic is_load(mem_op_t op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

endpackage

`default_nettype wire

// ==== include/mem_stage_config.svh ====
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Data memory geometry
//////////////////////////////////////////////////////////////////////

// Width of one memory word and of the load and store data paths.
`define MEM_DATA_W 32

// Byte lanes per word, one write enable bit each.
`define MEM_LANES 4

// Word address bits of the data RAM.
// The byte address carries two more bits for the lane offset.
`define MEM_ADDR_W 8

`endif
